/* common/mlaccel_defs.svh */
`ifndef MLACCEL_DEFS_SVH
`define MLACCEL_DEFS_SVH

`define MLA_NB          2   // 64-bit coefficient halves per entry
`define MLA_COEFF_SIZE  512
`define MLA_MADDR_W     17  // Byte address field of an instruction
`define MLA_CADDR_W     9
`define MLA_OPCODE_W    6
`define MLA_ADDR_W      16  // Memory word address
`define MLA_DATA_W      64
`define MLA_ACC_W       32
`define MLA_SUM_W       20
`define MLA_MEM_LATENCY 2   // Read data follows mem_ren by this many cycles

`define MLA_OP_LOADCOEFF0 6'd5
`define MLA_OP_LOADCOEFF1 6'd6
`define MLA_OP_SETVBP     6'd8
`define MLA_OP_ADDVBP     6'd9
`define MLA_OP_SETLBP     6'd10
`define MLA_OP_ADDLBP     6'd11
`define MLA_OP_SETSBP     6'd12
`define MLA_OP_ADDSBP     6'd13
`define MLA_OP_SETCBP     6'd14
`define MLA_OP_ADDCBP     6'd15
`define MLA_OP_STORE      6'd16
`define MLA_OP_STORE0     6'd17
`define MLA_OP_STORE1     6'd18
`define MLA_OP_RELU       6'd20
`define MLA_OP_RELU0      6'd21
`define MLA_OP_RELU1      6'd22
`define MLA_OP_LDSET      6'd28
`define MLA_OP_LDSET0     6'd29
`define MLA_OP_LDSET1     6'd30
`define MLA_OP_MACC       6'd40
`define MLA_OP_MACCZ      6'd42

`endif

/* common/mlaccel_pkg.sv */
`include "mlaccel_defs.svh"

package mlaccel_pkg;

	// Instruction word, opcode in the low bits
	typedef struct packed {
		logic [`MLA_MADDR_W-1:0]  maddr;
		logic [`MLA_CADDR_W-1:0]  caddr;
		logic [`MLA_OPCODE_W-1:0] opcode;
	} insn_t;

	// Token carried from stage to stage
	typedef struct packed {
		logic  valid;
		insn_t insn;
	} stage_t;

	// One requester's view of the shared memory port.
	// Idle requesters drive all zero so the port can merge by OR.
	typedef struct packed {
		logic                     ren;
		logic [`MLA_DATA_W/8-1:0] wen;   // Byte enables
		logic [`MLA_ADDR_W-1:0]   addr;
		logic [`MLA_DATA_W-1:0]   wdata;
	} mem_req_t;

	typedef union packed {
		logic signed [`MLA_DATA_W/8-1:0][7:0] bytes;  // MACC operand lanes
		logic [1:0][`MLA_ACC_W-1:0]           halves; // LdSet words, acc0 low
	} mem_word_u;

endpackage

/* datapath/accum_unit.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module accum_unit (
	input  logic                         clock,
	input  logic                         reset,
	input  mlaccel_pkg::stage_t          s5,
	input  logic signed [`MLA_SUM_W-1:0] sum0,
	input  logic signed [`MLA_SUM_W-1:0] sum1,
	input  mlaccel_pkg::mem_word_u       mem_rdata,
	output mlaccel_pkg::mem_req_t        rd1,
	output mlaccel_pkg::stage_t          s9,
	output logic [7:0]                   sat0,
	output logic [7:0]                   sat1
);
	localparam int EXT_W = `MLA_ACC_W - `MLA_SUM_W;

	mlaccel_pkg::stage_t s6;
	mlaccel_pkg::stage_t s7;
	mlaccel_pkg::stage_t s8;
	logic [`MLA_MADDR_W-1:0]      lbp;
	logic [`MLA_MADDR_W-1:0]      load_addr;
	logic signed [`MLA_ACC_W-1:0] acc0;
	logic signed [`MLA_ACC_W-1:0] acc1;
	logic signed [`MLA_ACC_W-1:0] sum0_ext;
	logic signed [`MLA_ACC_W-1:0] sum1_ext;
	logic signed [`MLA_ACC_W-1:0] shift0;
	logic signed [`MLA_ACC_W-1:0] shift1;

	function automatic logic [7:0] saturate(input logic signed [`MLA_ACC_W-1:0] v);
		if (&v[`MLA_ACC_W-1:7] == |v[`MLA_ACC_W-1:7]) begin
			return v[7:0];
		end
		return v[`MLA_ACC_W-1] ? 8'h80 : 8'h7f; // Clamp to -128 or 127
	endfunction

	assign load_addr = s5.insn.maddr + lbp;
	assign sum0_ext = {{EXT_W{sum0[`MLA_SUM_W-1]}}, sum0};
	assign sum1_ext = {{EXT_W{sum1[`MLA_SUM_W-1]}}, sum1};

	always_ff @(posedge clock) begin
		s6 <= s5;
		s7 <= s6;
		s8 <= s7;
		s9 <= s8;
		if (reset) begin
			s6.valid <= 1'b0;
			s7.valid <= 1'b0;
			s8.valid <= 1'b0;
			s9.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		rd1 <= '0;
		if (s5.valid) begin
			case (s5.insn.opcode)
				`MLA_OP_SETLBP, `MLA_OP_ADDLBP: begin
					lbp <= s5.insn.maddr + (s5.insn.opcode[0] ? lbp : '0);
				end
				`MLA_OP_LDSET, `MLA_OP_LDSET0, `MLA_OP_LDSET1: begin
					rd1.ren <= 1'b1;
					rd1.addr <= load_addr[`MLA_MADDR_W-1:1];
				end
				default: ;
			endcase
		end
		if (reset) begin
			rd1 <= '0;
		end
	end

	// Stage 8, both the adder sums and read-1 data land here
	always_ff @(posedge clock) begin
		if (s8.valid) begin
			case (s8.insn.opcode)
				`MLA_OP_MACC: begin
					acc0 <= acc0 + sum0_ext;
					acc1 <= acc1 + sum1_ext;
				end
				`MLA_OP_MACCZ: begin
					acc0 <= sum0_ext;
					acc1 <= sum1_ext;
				end
				`MLA_OP_LDSET: begin
					acc0 <= mem_rdata.halves[0];
					acc1 <= mem_rdata.halves[1];
				end
				`MLA_OP_LDSET0: acc0 <= mem_rdata.halves[0];
				`MLA_OP_LDSET1: acc1 <= mem_rdata.halves[1];
				default: ;
			endcase
		end
	end

	assign shift0 = acc0 >>> s8.insn.caddr; // caddr doubles as shift count
	assign shift1 = acc1 >>> s8.insn.caddr;

	always_ff @(posedge clock) begin
		sat0 <= saturate(shift0);
		sat1 <= saturate(shift1);
	end

endmodule

/* datapath/coeff_bank.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module coeff_bank (
	input  logic                           clock,
	input  logic                           reset,
	input  mlaccel_pkg::stage_t            s2,
	input  mlaccel_pkg::mem_word_u         mem_rdata,
	output mlaccel_pkg::stage_t            s5,
	output logic [`MLA_NB*`MLA_DATA_W-1:0] coeff
);
	logic [`MLA_NB-1:0][`MLA_DATA_W-1:0] coeff_mem [`MLA_COEFF_SIZE];
	mlaccel_pkg::stage_t     s3;
	mlaccel_pkg::stage_t     s4;
	logic [`MLA_CADDR_W-1:0] cbp;
	logic [`MLA_CADDR_W-1:0] rd_addr;

	assign rd_addr = s3.insn.caddr + cbp;

	always_ff @(posedge clock) begin
		s3 <= s2;
		s4 <= s3;
		s5 <= s4;
		if (reset) begin
			s3.valid <= 1'b0;
			s4.valid <= 1'b0;
			s5.valid <= 1'b0;
		end
	end

	// Stage 3, the read sees CBP before this instruction's own update
	always_ff @(posedge clock) begin
		coeff <= coeff_mem[rd_addr];
		if (s3.valid && (s3.insn.opcode == `MLA_OP_SETCBP ||
				s3.insn.opcode == `MLA_OP_ADDCBP)) begin
			cbp <= s3.insn.caddr + (s3.insn.opcode[0] ? cbp : '0);
		end
	end

	// Stage 4 is where read-0 data arrives
	always_ff @(posedge clock) begin
		if (s4.valid) begin
			if (s4.insn.opcode == `MLA_OP_LOADCOEFF0) begin
				coeff_mem[s4.insn.caddr][0] <= mem_rdata; // Low half
			end
			if (s4.insn.opcode == `MLA_OP_LOADCOEFF1) begin
				coeff_mem[s4.insn.caddr][1] <= mem_rdata;
			end
		end
	end

endmodule

/* datapath/simd_mac.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module simd_mac (
	input  logic                           clock,
	input  mlaccel_pkg::mem_word_u         data,
	input  logic [`MLA_NB*`MLA_DATA_W-1:0] coeff,
	output logic signed [`MLA_SUM_W-1:0]   sum0,
	output logic signed [`MLA_SUM_W-1:0]   sum1
);
	localparam int LANES = `MLA_DATA_W / 8;
	localparam int MULS  = `MLA_NB * LANES;
	localparam int EXT_W = `MLA_SUM_W - 16;

	logic signed [15:0] prod_r1 [MULS];
	logic signed [15:0] prod_r2 [MULS];
	logic signed [15:0] prod_r3 [MULS];
	logic signed [`MLA_SUM_W-1:0] tree [`MLA_NB];

	// Each data byte meets the same lane of both coefficient halves
	always_ff @(posedge clock) begin
		for (int i = 0; i < MULS; i++) begin
			prod_r1[i] <= 16'($signed(data.bytes[i % LANES])) *
				16'($signed(coeff[i*8 +: 8]));
			prod_r2[i] <= prod_r1[i];
			prod_r3[i] <= prod_r2[i];
		end
	end

	always_comb begin
		for (int h = 0; h < `MLA_NB; h++) begin
			tree[h] = '0;
			for (int k = 0; k < LANES; k++) begin
				tree[h] = tree[h] + {{EXT_W{prod_r3[h*LANES + k][15]}}, prod_r3[h*LANES + k]};
			end
		end
	end

	always_ff @(posedge clock) begin
		sum0 <= tree[0];
		sum1 <= tree[1];
	end

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module issue_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  cmd_valid,
	input  mlaccel_pkg::insn_t    cmd_insn,
	input  logic                  stall,
	output mlaccel_pkg::stage_t   s1,
	output mlaccel_pkg::stage_t   s2,
	output mlaccel_pkg::mem_req_t rd0,
	output logic                  tick_simd,
	output logic                  tick_nosimd
);
	logic [`MLA_MADDR_W-1:0] vbp;
	logic [`MLA_MADDR_W-1:0] vec_addr;
	logic                    s2_simd;

	assign vec_addr = s1.insn.maddr + vbp;

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1.valid <= cmd_valid; // cmd_ready is !stall
			s1.insn <= cmd_insn;
		end
		if (reset) begin
			s1.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		s2.valid <= s1.valid && !stall;
		s2.insn <= s1.insn;
		rd0 <= '0;
		if (s1.valid && !stall) begin
			case (s1.insn.opcode)
				`MLA_OP_LOADCOEFF0, `MLA_OP_LOADCOEFF1: begin
					rd0.ren <= 1'b1;
					rd0.addr <= s1.insn.maddr[`MLA_MADDR_W-1:1]; // Byte pair to word
				end
				`MLA_OP_SETVBP, `MLA_OP_ADDVBP: begin
					vbp <= s1.insn.maddr + (s1.insn.opcode[0] ? vbp : '0);
				end
				`MLA_OP_MACC, `MLA_OP_MACCZ: begin
					rd0.ren <= 1'b1;
					rd0.addr <= vec_addr[`MLA_MADDR_W-1:1];
				end
				default: ;
			endcase
		end
		if (reset) begin
			s2.valid <= 1'b0;
			rd0 <= '0;
		end
	end

	assign s2_simd = (s2.insn.opcode == `MLA_OP_MACC) || (s2.insn.opcode == `MLA_OP_MACCZ);
	assign tick_simd = s2.valid && s2_simd;
	assign tick_nosimd = s2.valid && !s2_simd;

endmodule

/* hw/mem_port_sched.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module mem_port_sched (
	input  logic                     clock,
	input  logic                     reset,
	input  mlaccel_pkg::stage_t      s1,
	output logic                     stall,
	output logic                     cmd_ready,
	input  mlaccel_pkg::mem_req_t    rd0,
	input  mlaccel_pkg::mem_req_t    rd1,
	input  mlaccel_pkg::mem_req_t    wr,
	output logic                     mem_ren,
	output logic [`MLA_DATA_W/8-1:0] mem_wen,
	output logic [`MLA_ADDR_W-1:0]   mem_addr,
	output logic [`MLA_DATA_W-1:0]   mem_wdata
);
	// Slot k is the port cycle k+1 after the current one.
	// Reads issue latency cycles before stage 4 or 8 consumes the data.
	localparam int RD0_SLOT = 4 - `MLA_MEM_LATENCY - 2;
	localparam int RD1_SLOT = 8 - `MLA_MEM_LATENCY - 2;
	localparam int WR_SLOT  = 8;               // Write leaves after stage 9
	localparam int RES_W    = WR_SLOT + 1;

	logic [RES_W-1:0]      res_vec;
	logic [RES_W-1:0]      res_mask;
	mlaccel_pkg::mem_req_t merged;

	always_comb begin
		res_mask = '0;
		if (s1.valid) begin
			case (s1.insn.opcode)
				`MLA_OP_LOADCOEFF0, `MLA_OP_LOADCOEFF1,
				`MLA_OP_MACC, `MLA_OP_MACCZ:                     res_mask[RD0_SLOT] = 1'b1;
				`MLA_OP_LDSET, `MLA_OP_LDSET0, `MLA_OP_LDSET1:   res_mask[RD1_SLOT] = 1'b1;
				`MLA_OP_STORE, `MLA_OP_STORE0, `MLA_OP_STORE1,
				`MLA_OP_RELU, `MLA_OP_RELU0, `MLA_OP_RELU1:      res_mask[WR_SLOT] = 1'b1;
				default: ;
			endcase
		end
	end

	assign stall = |(res_vec & res_mask);
	assign cmd_ready = !stall;

	always_ff @(posedge clock) begin
		res_vec <= (res_vec | res_mask) >> 1;
		if (reset) begin
			res_vec <= '0;
		end
	end

	assign merged = rd0 | rd1 | wr; // At most one active per cycle
	assign mem_ren = merged.ren;
	assign mem_wen = merged.wen;
	assign mem_addr = merged.addr;
	assign mem_wdata = merged.wdata;

endmodule

/* hw/mlaccel_compute.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module mlaccel_compute (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       cmd_valid,
	output logic                       cmd_ready,
	input  mlaccel_pkg::insn_t         cmd_insn,
	output logic                       mem_ren,
	output logic [`MLA_DATA_W/8-1:0]   mem_wen,
	output logic [`MLA_ADDR_W-1:0]     mem_addr,
	output logic [`MLA_DATA_W-1:0]     mem_wdata,
	input  logic [`MLA_DATA_W-1:0]     mem_rdata,
	output logic                       busy,
	output logic                       tick_simd,
	output logic                       tick_nosimd
);
	mlaccel_pkg::stage_t   s1;
	mlaccel_pkg::stage_t   s2;
	mlaccel_pkg::stage_t   s5;
	mlaccel_pkg::stage_t   s9;
	mlaccel_pkg::mem_req_t rd0;
	mlaccel_pkg::mem_req_t rd1;
	mlaccel_pkg::mem_req_t wr;
	logic                  stall;
	logic [`MLA_NB*`MLA_DATA_W-1:0] coeff;
	logic signed [`MLA_SUM_W-1:0]   sum0;
	logic signed [`MLA_SUM_W-1:0]   sum1;
	logic [7:0]            sat0;
	logic [7:0]            sat1;
	logic [1:0]            s34_valid;  // Shadows of stages 3 and 4
	logic [2:0]            s678_valid; // Shadows of stages 6 to 8

	issue_stage issue_stage_inst (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .cmd_insn(cmd_insn),
		.stall(stall), .s1(s1), .s2(s2), .rd0(rd0),
		.tick_simd(tick_simd), .tick_nosimd(tick_nosimd)
	);

	mem_port_sched mem_port_sched_inst (
		.clock(clock), .reset(reset), .s1(s1), .stall(stall), .cmd_ready(cmd_ready),
		.rd0(rd0), .rd1(rd1), .wr(wr), .mem_ren(mem_ren), .mem_wen(mem_wen),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	coeff_bank coeff_bank_inst (
		.clock(clock), .reset(reset), .s2(s2), .mem_rdata(mem_rdata), .s5(s5), .coeff(coeff)
	);

	simd_mac simd_mac_inst (
		.clock(clock), .data(mem_rdata), .coeff(coeff), .sum0(sum0), .sum1(sum1)
	);

	accum_unit accum_unit_inst (
		.clock(clock), .reset(reset), .s5(s5), .sum0(sum0), .sum1(sum1),
		.mem_rdata(mem_rdata), .rd1(rd1), .s9(s9), .sat0(sat0), .sat1(sat1)
	);

	store_unit store_unit_inst (
		.clock(clock), .reset(reset), .s9(s9), .sat0(sat0), .sat1(sat1), .wr(wr)
	);

	always_ff @(posedge clock) begin
		s34_valid <= {s34_valid[0], s2.valid};
		s678_valid <= {s678_valid[1:0], s5.valid};
		if (reset) begin
			s34_valid <= '0;
			s678_valid <= '0;
		end
	end

	assign busy = s1.valid | s2.valid | (|s34_valid) | s5.valid | (|s678_valid);

endmodule

/* hw/store_unit.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module store_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  mlaccel_pkg::stage_t   s9,
	input  logic [7:0]            sat0,
	input  logic [7:0]            sat1,
	output mlaccel_pkg::mem_req_t wr
);
	logic [`MLA_MADDR_W-1:0] sbp;
	logic [`MLA_MADDR_W-1:0] byte_addr;
	logic [1:0]              lane_en;
	logic                    relu;
	logic [7:0]              byte0;
	logic [7:0]              byte1;
	logic [`MLA_DATA_W-1:0]  pair_word;

	assign byte_addr = s9.insn.maddr + sbp;

	always_comb begin
		lane_en = 2'b00;
		relu = 1'b0;
		if (s9.valid) begin
			case (s9.insn.opcode)
				`MLA_OP_STORE:  lane_en = 2'b11;
				`MLA_OP_STORE0: lane_en = 2'b01; // acc0 only
				`MLA_OP_STORE1: lane_en = 2'b10;
				`MLA_OP_RELU: begin
					lane_en = 2'b11;
					relu = 1'b1;
				end
				`MLA_OP_RELU0: begin
					lane_en = 2'b01;
					relu = 1'b1;
				end
				`MLA_OP_RELU1: begin
					lane_en = 2'b10;
					relu = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign byte0 = (relu && sat0[7]) ? 8'h00 : sat0;
	assign byte1 = (relu && sat1[7]) ? 8'h00 : sat1;
	assign pair_word = {{(`MLA_DATA_W-16){1'b0}}, byte1, byte0};

	always_ff @(posedge clock) begin
		wr <= '0;
		if (|lane_en) begin
			// Odd byte address moves the pair up one lane
			wr.wen <= {{(`MLA_DATA_W/8-2){1'b0}}, lane_en} << byte_addr[0];
			wr.addr <= byte_addr[`MLA_MADDR_W-1:1];
			wr.wdata <= pair_word << (byte_addr[0] ? 8 : 0);
		end
		if (s9.valid && (s9.insn.opcode == `MLA_OP_SETSBP ||
				s9.insn.opcode == `MLA_OP_ADDSBP)) begin
			sbp <= s9.insn.maddr + (s9.insn.opcode[0] ? sbp : '0);
		end
		if (reset) begin
			wr <= '0;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the mlaccel testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_mlaccel \
	-Mdir obj_dir -o tb_mlaccel_sim
./obj_dir/tb_mlaccel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* src.f */
+incdir+common
common/mlaccel_pkg.sv
hw/issue_stage.sv
hw/mem_port_sched.sv
datapath/coeff_bank.sv
datapath/simd_mac.sv
datapath/accum_unit.sv
hw/store_unit.sv
hw/mlaccel_compute.sv
verif/tb_mem_model.sv
verif/tb_mlaccel.sv

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module tb_mem_model (
	input  logic                     clock,
	input  logic                     ren,
	input  logic [`MLA_DATA_W/8-1:0] wen,
	input  logic [`MLA_ADDR_W-1:0]   addr,
	input  logic [`MLA_DATA_W-1:0]   wdata,
	output logic [`MLA_DATA_W-1:0]   rdata
);
	logic [`MLA_DATA_W-1:0] mem [1 << `MLA_ADDR_W];
	logic [`MLA_DATA_W-1:0] rd_pipe [`MLA_MEM_LATENCY];

	initial begin
		for (int i = 0; i < (1 << `MLA_ADDR_W); i++) begin
			mem[i] = {16'(i), 16'(~i), 16'(i * 7), 16'(i ^ 16'ha5c3)}; // Whole-address fill
		end
		for (int i = 0; i < `MLA_MEM_LATENCY; i++) begin
			rd_pipe[i] = '0;
		end
	end

	// Read data leaves the last pipe register
	assign rdata = rd_pipe[`MLA_MEM_LATENCY-1];

	always @(posedge clock) begin
		rd_pipe[0] <= ren ? mem[addr] : '0;
		for (int i = 1; i < `MLA_MEM_LATENCY; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		for (int b = 0; b < `MLA_DATA_W/8; b++) begin
			if (wen[b]) begin
				mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

endmodule

/* verif/tb_mlaccel.sv */
`timescale 1ns/1ps
`include "mlaccel_defs.svh"

module tb_mlaccel;

	localparam int PROG_CYCLES = 500; // Rough length of the directed program
	localparam int IDLE_LIMIT = 100;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wen;
		logic [63:0] data;
	} exp_write_t;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic cmd_valid = 1'b0;
	logic cmd_ready;
	mlaccel_pkg::insn_t cmd_insn = '0;
	logic mem_ren;
	logic [7:0] mem_wen;
	logic [15:0] mem_addr;
	logic [63:0] mem_wdata;
	logic [63:0] mem_rdata;
	logic busy;
	logic tick_simd;
	logic tick_nosimd;

	int errors = 0;
	int exp_simd = 0;
	int exp_nosimd = 0;
	int seen_simd = 0;
	int seen_nosimd = 0;
	logic saw_stall = 1'b0;
	logic [31:0] lcg_state = 32'h4bc6b664;
	exp_write_t exp_q [$];

	// Reference state, advanced in program order
	logic [16:0] ref_vbp, ref_lbp, ref_sbp;
	logic [8:0] ref_cbp;
	logic signed [31:0] ref_acc0, ref_acc1;
	logic [127:0] ref_coeff [512];
	logic [63:0] ref_mem [int];

	mlaccel_compute mlaccel_compute_inst (
		.clock(clock), .reset(reset), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_insn(cmd_insn), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .busy(busy),
		.tick_simd(tick_simd), .tick_nosimd(tick_nosimd)
	);

	tb_mem_model mem_model_inst (
		.clock(clock), .ren(mem_ren), .wen(mem_wen), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic signed [31:0] dot8(input logic [63:0] d, input logic [63:0] c);
		int s;
		s = 0;
		for (int k = 0; k < 8; k++) begin
			s += $signed(d[k*8 +: 8]) * $signed(c[k*8 +: 8]);
		end
		return s;
	endfunction

	function automatic logic [7:0] clamp8(input logic signed [31:0] v);
		if (v > 127) return 8'h7f;
		if (v < -128) return 8'h80;
		return v[7:0];
	endfunction

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic preload(input int word, input logic [63:0] value);
		mem_model_inst.mem[word] = value;
		ref_mem[word] = value;
	endtask

	task automatic model_store(input logic [5:0] op, input logic [16:0] maddr,
			input logic [8:0] sh);
		logic [7:0] b0, b1;
		logic [1:0] en;
		logic [16:0] ba;
		exp_write_t w;
		b0 = clamp8(ref_acc0 >>> sh);
		b1 = clamp8(ref_acc1 >>> sh);
		if (op >= `MLA_OP_RELU) begin
			b0 = b0[7] ? 8'h00 : b0;
			b1 = b1[7] ? 8'h00 : b1;
		end
		en = (op == `MLA_OP_STORE0 || op == `MLA_OP_RELU0) ? 2'b01 :
			(op == `MLA_OP_STORE1 || op == `MLA_OP_RELU1) ? 2'b10 : 2'b11;
		ba = maddr + ref_sbp;
		w.addr = ba[16:1];
		w.wen = ba[0] ? {5'b0, en, 1'b0} : {6'b0, en};
		w.data = ba[0] ? {40'b0, b1, b0, 8'b0} : {48'b0, b1, b0};
		exp_q.push_back(w);
	endtask

	// Mirror of the instruction set rules
	task automatic model_insn(input logic [5:0] op, input logic [16:0] maddr,
			input logic [8:0] caddr);
		logic [63:0] d;
		logic [127:0] c;
		case (op)
			`MLA_OP_LOADCOEFF0: ref_coeff[caddr][63:0] = ref_mem[int'(maddr[16:1])];
			`MLA_OP_LOADCOEFF1: ref_coeff[caddr][127:64] = ref_mem[int'(maddr[16:1])];
			`MLA_OP_SETVBP: ref_vbp = maddr;
			`MLA_OP_ADDVBP: ref_vbp = ref_vbp + maddr;
			`MLA_OP_SETLBP: ref_lbp = maddr;
			`MLA_OP_ADDLBP: ref_lbp = ref_lbp + maddr;
			`MLA_OP_SETSBP: ref_sbp = maddr;
			`MLA_OP_ADDSBP: ref_sbp = ref_sbp + maddr;
			`MLA_OP_SETCBP: ref_cbp = caddr;
			`MLA_OP_ADDCBP: ref_cbp = ref_cbp + caddr;
			`MLA_OP_MACC, `MLA_OP_MACCZ: begin
				d = ref_mem[int'(17'(maddr + ref_vbp) >> 1)];
				c = ref_coeff[9'(caddr + ref_cbp)];
				if (op == `MLA_OP_MACCZ) begin
					ref_acc0 = 0;
					ref_acc1 = 0;
				end
				ref_acc0 = ref_acc0 + dot8(d, c[63:0]);
				ref_acc1 = ref_acc1 + dot8(d, c[127:64]);
			end
			`MLA_OP_LDSET, `MLA_OP_LDSET0, `MLA_OP_LDSET1: begin
				d = ref_mem[int'(17'(maddr + ref_lbp) >> 1)];
				if (op != `MLA_OP_LDSET1) ref_acc0 = d[31:0];
				if (op != `MLA_OP_LDSET0) ref_acc1 = d[63:32];
			end
			`MLA_OP_STORE, `MLA_OP_STORE0, `MLA_OP_STORE1,
			`MLA_OP_RELU, `MLA_OP_RELU0, `MLA_OP_RELU1: model_store(op, maddr, caddr);
			default: ;
		endcase
	endtask

	task automatic send(input logic [5:0] op, input logic [16:0] maddr, input logic [8:0] caddr);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		cmd_valid = 1'b1;
		cmd_insn = '{maddr: maddr, caddr: caddr, opcode: op};
		while (!taken && waited < IDLE_LIMIT) begin
			@(negedge clock);
			taken = cmd_ready;
			if (!cmd_ready) saw_stall = 1'b1;
			@(posedge clock);
			waited++;
		end
		#2;
		cmd_valid = 1'b0;
		if (!taken) begin
			$display("Command port never accepted opcode %0d", op);
			errors++;
		end else begin
			if (op == `MLA_OP_MACC || op == `MLA_OP_MACCZ) exp_simd++;
			else exp_nosimd++;
			model_insn(op, maddr, caddr);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clock);
		while (busy && n < IDLE_LIMIT) begin
			@(negedge clock);
			n++;
		end
		if (busy) begin
			$display("busy stayed high after the program drained");
			errors++;
		end
		repeat (4) @(posedge clock); // Let the last write leave
		#2;
	endtask

	// Port monitor
	always @(negedge clock) begin
		exp_write_t w;
		logic [63:0] mask;
		if (!reset) begin
			assert (!(mem_ren && (|mem_wen))) else begin
				$display("Read and write were active on the memory port together at %0t", $time);
				errors++;
			end
			if (tick_simd) seen_simd++;
			if (tick_nosimd) seen_nosimd++;
			if (|mem_wen) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected memory write at %0t", $time);
					errors++;
				end else begin
					w = exp_q.pop_front();
					for (int b = 0; b < 8; b++) mask[b*8 +: 8] = {8{w.wen[b]}};
					check_eq("mem_addr", 64'(w.addr), 64'(mem_addr));
					check_eq("mem_wen", 64'(w.wen), 64'(mem_wen));
					check_eq("mem_wdata", w.data & mask, mem_wdata & mask);
				end
			end
		end
	end

	initial begin
		#((PROG_CYCLES + 200) * 20);
		$display("Watchdog expired before the program finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		@(negedge clock);
		check_eq("mem_ren", 0, mem_ren);
		check_eq("mem_wen", 0, mem_wen);
		check_eq("busy", 0, busy);
		check_eq("tick_simd", 0, tick_simd);
		check_eq("tick_nosimd", 0, tick_nosimd);
		check_eq("cmd_ready", 1, cmd_ready);
		@(posedge clock);
		#2;

		// Coefficients and data, partly fixed and partly random
		preload(16'h10, 64'h7f80_0102_fe03_7f7f);
		preload(16'h11, {lcg_next(), lcg_next()});
		preload(16'h12, {lcg_next(), lcg_next()});
		preload(16'h13, 64'h8080_8080_8080_8080);
		preload(16'h80, {lcg_next(), lcg_next()});
		preload(16'h81, 64'h0102_0304_fffe_fdfc);
		preload(16'hc0, {32'hffff_f123, 32'h0000_0a5c});
		preload(16'hc1, {lcg_next(), lcg_next()});
		preload(16'hc2, {32'h7fff_ffff, 32'h8000_0000});
		preload(16'hc8, {32'hffe0_0000, 32'h0001_2345}); // Negative acc1 for ReLU
		preload(16'hca, {lcg_next(), lcg_next()});

		send(`MLA_OP_LOADCOEFF0, 17'h20, 9'd3);
		send(`MLA_OP_LOADCOEFF1, 17'h22, 9'd3);
		send(`MLA_OP_LOADCOEFF0, 17'h24, 9'd5);
		send(`MLA_OP_LOADCOEFF1, 17'h26, 9'd5);
		send(`MLA_OP_SETCBP, 17'h0, 9'd2);
		send(`MLA_OP_SETVBP, 17'h100, 9'd0);
		wait_idle();

		// MACC, stores and ReLU
		send(`MLA_OP_MACCZ, 17'h0, 9'd1);
		send(`MLA_OP_SETSBP, 17'h401, 9'd0);
		send(`MLA_OP_STORE, 17'h0, 9'd0);
		send(`MLA_OP_MACC, 17'h2, 9'd3);
		send(`MLA_OP_STORE0, 17'h2, 9'd2);
		send(`MLA_OP_STORE1, 17'h5, 9'd0);
		send(`MLA_OP_RELU, 17'h8, 9'd0);
		send(`MLA_OP_RELU0, 17'hb, 9'd4);
		send(`MLA_OP_RELU1, 17'hc, 9'd1);
		send(`MLA_OP_ADDSBP, 17'h10, 9'd0);
		send(`MLA_OP_STORE, 17'h0, 9'd30);
		wait_idle();

		// Accumulator loads through LBP
		send(`MLA_OP_SETLBP, 17'h180, 9'd0);
		send(`MLA_OP_LDSET, 17'h0, 9'd0);
		send(`MLA_OP_STORE, 17'h20, 9'd4);
		send(`MLA_OP_LDSET0, 17'h2, 9'd0);
		send(`MLA_OP_STORE, 17'h23, 9'd8);
		send(`MLA_OP_LDSET1, 17'h4, 9'd0);
		send(`MLA_OP_STORE1, 17'h26, 9'd0);
		send(`MLA_OP_ADDLBP, 17'h10, 9'd0);
		send(`MLA_OP_LDSET, 17'h0, 9'd12);
		send(`MLA_OP_STORE, 17'h29, 9'd12);
		wait_idle();

		// Store then LdSet four slots later must stall the command port
		send(`MLA_OP_LDSET, 17'h4, 9'd0);
		send(`MLA_OP_STORE, 17'h30, 9'd0);
		send(6'd0, 17'h0, 9'd0);
		send(6'd0, 17'h0, 9'd0);
		send(6'd0, 17'h0, 9'd0);
		send(`MLA_OP_LDSET, 17'h0, 9'd0);
		send(`MLA_OP_RELU, 17'h33, 9'd0);
		wait_idle();

		assert (saw_stall) else begin
			$display("cmd_ready never dropped for a conflicting command");
			errors++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d expected writes never reached the memory port", exp_q.size());
			errors++;
		end
		check_eq("tick_simd count", 64'(exp_simd), 64'(seen_simd));
		check_eq("tick_nosimd count", 64'(exp_nosimd), 64'(seen_nosimd));
		check_eq("busy", 0, busy);

		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
